// ==== source/coreDefs.sv ====
package coreDefs;

    localparam int xlen = 64;
    localparam int memPortBits = 64;

    typedef logic [xlen-1:0] wordT;
    typedef logic [xlen-1:0] addrT;
    typedef logic [31:0] instT;
    typedef logic [4:0] regIdxT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor
    } aluOpT;

    typedef enum logic [1:0] {
        memNone,
        memLoad,
        memStore
    } memOpT;

    // base opcodes of the supported RV64I subset
    localparam logic [6:0] opReg = 7'b0110011;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;

    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    localparam addrT resetPc = '0;

endpackage

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ns

module fetchUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           redirect,
    input  coreDefs::addrT redirectPc,
    input  logic           memBusy,
    output logic           fetchReq,
    output coreDefs::addrT fetchAddr,
    input  logic           fetchDone,
    input  coreDefs::wordT fetchData,
    output logic           ifValid,
    output coreDefs::addrT ifPc,
    output coreDefs::instT ifInst
);
    import coreDefs::*;

    localparam int halfBits = memPortBits / 2;

    addrT pc;
    logic dropResp;
    logic accept;

    // a response that cannot be taken under stall is dropped and fetched again
    assign accept = fetchDone && !dropResp && !redirect && (!memBusy || !ifValid);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
            fetchReq <= 1'b0;
            dropResp <= 1'b0;
            ifValid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (accept) begin
                pc <= fetchAddr + 64'd4;
            end
            if (fetchDone) begin
                fetchReq <= 1'b0;
            end else if (!fetchReq) begin
                fetchReq <= 1'b1;
            end
            // in-flight fetch of the old path
            if (fetchDone) begin
                dropResp <= 1'b0;
            end else if (redirect && fetchReq) begin
                dropResp <= 1'b1;
            end
            if (redirect) begin
                ifValid <= 1'b0;
            end else if (accept) begin
                ifValid <= 1'b1;
            end else if (!memBusy) begin
                ifValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fetchReq) begin
            fetchAddr <= redirect ? redirectPc : pc;
        end
        if (accept) begin
            ifPc <= fetchAddr;
            ifInst <= fetchAddr[2] ? fetchData[memPortBits-1:halfBits] : fetchData[halfBits-1:0];
        end
    end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             redirect,
    input  logic             memBusy,
    input  logic             ifValid,
    input  coreDefs::addrT   ifPc,
    input  coreDefs::instT   ifInst,
    input  logic             wbWe,
    input  coreDefs::regIdxT wbRd,
    input  coreDefs::wordT   wbData,
    output logic             idValid,
    output coreDefs::addrT   idPc,
    output coreDefs::regIdxT idRs1,
    output coreDefs::regIdxT idRs2,
    output coreDefs::regIdxT idRd,
    output coreDefs::wordT   idVal1,
    output coreDefs::wordT   idVal2,
    output coreDefs::wordT   idImm,
    output coreDefs::aluOpT  idAluOp,
    output coreDefs::memOpT  idMemOp,
    output logic             idUseImm,
    output logic             idRegWe,
    output logic             idIsBranch,
    output logic             idBne,
    output logic             idIsJal
);
    import coreDefs::*;

    wordT regFile [32];

    logic [6:0] opcode;
    logic [2:0] funct3;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT immI;
    wordT immS;
    wordT immB;
    wordT immJ;
    logic legal;
    logic writesRd;
    logic useImm;
    logic isBranch;
    logic isJal;
    aluOpT aluOp;
    memOpT memOp;
    wordT imm;

    assign opcode = ifInst[6:0];
    assign funct3 = ifInst[14:12];
    assign rs1 = ifInst[19:15];
    assign rs2 = ifInst[24:20];
    assign rd = ifInst[11:7];

    assign immI = {{52{ifInst[31]}}, ifInst[31:20]};
    assign immS = {{52{ifInst[31]}}, ifInst[31:25], ifInst[11:7]};
    assign immB = {{51{ifInst[31]}}, ifInst[31], ifInst[7], ifInst[30:25], ifInst[11:8], 1'b0};
    assign immJ = {{43{ifInst[31]}}, ifInst[31], ifInst[19:12], ifInst[20], ifInst[30:21], 1'b0};

    // x0 reads zero and a same-cycle writeback is passed through
    function automatic wordT readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbWe && wbRd == idx) begin
            return wbData;
        end
        return regFile[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wbWe && wbRd != '0) begin
            regFile[wbRd] <= wbData;
        end
    end

    always_comb begin
        legal = 1'b0;
        writesRd = 1'b0;
        useImm = 1'b0;
        isBranch = 1'b0;
        isJal = 1'b0;
        aluOp = aluAdd;
        memOp = memNone;
        imm = immI;
        case (opcode)
            opReg: begin
                legal = 1'b1;
                writesRd = 1'b1;
                case (funct3)
                    3'b000: aluOp = ifInst[30] ? aluSub : aluAdd;
                    3'b100: aluOp = aluXor;
                    3'b110: aluOp = aluOr;
                    3'b111: aluOp = aluAnd;
                    default: legal = 1'b0;
                endcase
            end
            opImm: begin
                legal = funct3 == 3'b000;
                writesRd = 1'b1;
                useImm = 1'b1;
            end
            opLoad: begin
                legal = 1'b1;
                writesRd = 1'b1;
                useImm = 1'b1;
                memOp = memLoad;
            end
            opStore: begin
                legal = 1'b1;
                useImm = 1'b1;
                memOp = memStore;
                imm = immS;
            end
            opBranch: begin
                legal = funct3 == f3Beq || funct3 == f3Bne;
                isBranch = 1'b1;
                imm = immB;
            end
            opJal: begin
                legal = 1'b1;
                writesRd = 1'b1;
                isJal = 1'b1;
                imm = immJ;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN || redirect) begin
            idValid <= 1'b0;
        end else if (!memBusy) begin
            idValid <= ifValid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            idPc <= ifPc;
            idRs1 <= rs1;
            idRs2 <= rs2;
            idRd <= rd;
            idVal1 <= readReg(rs1);
            idVal2 <= readReg(rs2);
            idImm <= imm;
            idAluOp <= aluOp;
            idMemOp <= memOp;
            idUseImm <= useImm;
            idRegWe <= writesRd && rd != '0;
            idIsBranch <= isBranch;
            idBne <= funct3 == f3Bne;
            idIsJal <= isJal;
        end
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             memBusy,
    input  logic             idValid,
    input  coreDefs::addrT   idPc,
    input  coreDefs::regIdxT idRs1,
    input  coreDefs::regIdxT idRs2,
    input  coreDefs::regIdxT idRd,
    input  coreDefs::wordT   idVal1,
    input  coreDefs::wordT   idVal2,
    input  coreDefs::wordT   idImm,
    input  coreDefs::aluOpT  idAluOp,
    input  coreDefs::memOpT  idMemOp,
    input  logic             idUseImm,
    input  logic             idRegWe,
    input  logic             idIsBranch,
    input  logic             idBne,
    input  logic             idIsJal,
    input  logic             fwdValid,
    input  coreDefs::regIdxT fwdRd,
    input  coreDefs::wordT   fwdData,
    output logic             redirect,
    output coreDefs::addrT   redirectPc,
    output logic             exValid,
    output coreDefs::addrT   exPc,
    output coreDefs::regIdxT exRd,
    output logic             exRegWe,
    output coreDefs::memOpT  exMemOp,
    output coreDefs::wordT   exResult,
    output coreDefs::wordT   exStoreData
);
    import coreDefs::*;

    wordT src1;
    wordT src2;
    wordT opB;
    wordT aluOut;
    logic taken;

    // only the memory stage result can be newer than the register file
    assign src1 = (fwdValid && fwdRd == idRs1) ? fwdData : idVal1;
    assign src2 = (fwdValid && fwdRd == idRs2) ? fwdData : idVal2;
    assign opB = idUseImm ? idImm : src2;

    always_comb begin
        case (idAluOp)
            aluSub: aluOut = src1 - opB;
            aluAnd: aluOut = src1 & opB;
            aluOr: aluOut = src1 | opB;
            aluXor: aluOut = src1 ^ opB;
            default: aluOut = src1 + opB;
        endcase
    end

    assign taken = idIsBranch && ((src1 == src2) != idBne);

    // held instruction must not redirect twice
    assign redirect = idValid && !memBusy && (taken || idIsJal);
    assign redirectPc = idPc + idImm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else if (!memBusy) begin
            exValid <= idValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            exPc <= idPc;
            exRd <= idRd;
            exRegWe <= idRegWe;
            exMemOp <= idMemOp;
            exResult <= idIsJal ? idPc + 64'd4 : aluOut;
            exStoreData <= src2;
        end
    end

endmodule

// ==== source/memStage.sv ====
`timescale 1ns/1ns

module memStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exValid,
    input  coreDefs::addrT   exPc,
    input  coreDefs::regIdxT exRd,
    input  logic             exRegWe,
    input  coreDefs::memOpT  exMemOp,
    input  coreDefs::wordT   exResult,
    input  coreDefs::wordT   exStoreData,
    output logic             dataReq,
    output logic             dataWe,
    output coreDefs::addrT   dataAddr,
    output coreDefs::wordT   dataWdata,
    input  logic             dataDone,
    input  coreDefs::wordT   dataRdata,
    output logic             memBusy,
    output logic             fwdValid,
    output coreDefs::regIdxT fwdRd,
    output coreDefs::wordT   fwdData,
    output logic             wbWe,
    output coreDefs::regIdxT wbRd,
    output coreDefs::wordT   wbData,
    output logic             commitValid,
    output coreDefs::addrT   commitPc,
    output logic             commitRdWe,
    output coreDefs::regIdxT commitRd,
    output coreDefs::wordT   commitData
);
    import coreDefs::*;

    logic isAccess;

    assign isAccess = exValid && exMemOp != memNone;
    assign memBusy = isAccess && !dataDone;

    // request stays up with fixed fields until the done pulse
    always_ff @(posedge clk) begin
        if (!rstN || dataDone) begin
            dataReq <= 1'b0;
        end else if (isAccess) begin
            dataReq <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (isAccess && !dataReq) begin
            dataWe <= exMemOp == memStore;
            dataAddr <= exResult;
            dataWdata <= exStoreData;
        end
    end

    assign wbData = (exMemOp == memLoad) ? dataRdata : exResult;
    assign commitValid = exValid && (exMemOp == memNone || dataDone);
    assign wbWe = commitValid && exRegWe;
    assign wbRd = exRd;

    assign fwdValid = exValid && exRegWe;
    assign fwdRd = exRd;
    assign fwdData = wbData;

    assign commitPc = exPc;
    assign commitRdWe = exRegWe;
    assign commitRd = exRd;
    assign commitData = wbData;

endmodule

// ==== source/memArbiter.sv ====
`timescale 1ns/1ns

module memArbiter (
    input  logic           clk,
    input  logic           rstN,
    input  logic           fetchReq,
    input  coreDefs::addrT fetchAddr,
    output logic           fetchDone,
    output coreDefs::wordT fetchData,
    input  logic           dataReq,
    input  logic           dataWe,
    input  coreDefs::addrT dataAddr,
    input  coreDefs::wordT dataWdata,
    output logic           dataDone,
    output coreDefs::wordT dataRdata,
    output logic           memReq,
    output logic           memWe,
    output coreDefs::addrT memAddr,
    output coreDefs::wordT memWdata,
    input  coreDefs::wordT memRdata,
    input  logic           memReady
);

    typedef enum logic [1:0] {
        arbIdle,
        arbFetch,
        arbData
    } arbStateT;

    arbStateT state;

    // data side wins a tie
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= arbIdle;
        end else if (state == arbIdle) begin
            if (dataReq) begin
                state <= arbData;
            end else if (fetchReq) begin
                state <= arbFetch;
            end
        end else if (memReady) begin
            state <= arbIdle;
        end
    end

    assign memReq = state != arbIdle;
    assign memWe = state == arbData && dataWe;
    assign memAddr = (state == arbData) ? dataAddr : fetchAddr;
    assign memWdata = (state == arbData) ? dataWdata : '0;

    assign fetchDone = state == arbFetch && memReady;
    assign dataDone = state == arbData && memReady;
    assign fetchData = memRdata;
    assign dataRdata = memRdata;

endmodule

// ==== source/pipeCore.sv ====
`timescale 1ns/1ns

module pipeCore (
    input  logic           clk,
    input  logic           rstN,
    output logic           memReq,
    output logic           memWe,
    output coreDefs::addrT memAddr,
    output coreDefs::wordT memWdata,
    input  coreDefs::wordT memRdata,
    input  logic           memReady,
    output logic             commitValid,
    output coreDefs::addrT   commitPc,
    output logic             commitRdWe,
    output coreDefs::regIdxT commitRd,
    output coreDefs::wordT   commitData
);
    import coreDefs::*;

    // fetch side
    logic   fetchReq;
    addrT   fetchAddr;
    logic   fetchDone;
    wordT   fetchData;
    logic   ifValid;
    addrT   ifPc;
    instT   ifInst;

    // decode/execute register
    logic   idValid;
    addrT   idPc;
    regIdxT idRs1;
    regIdxT idRs2;
    regIdxT idRd;
    wordT   idVal1;
    wordT   idVal2;
    wordT   idImm;
    aluOpT  idAluOp;
    memOpT  idMemOp;
    logic   idUseImm;
    logic   idRegWe;
    logic   idIsBranch;
    logic   idBne;
    logic   idIsJal;

    // execute/memory register and control back to the front end
    logic   redirect;
    addrT   redirectPc;
    logic   exValid;
    addrT   exPc;
    regIdxT exRd;
    logic   exRegWe;
    memOpT  exMemOp;
    wordT   exResult;
    wordT   exStoreData;

    // memory stage
    logic   memBusy;
    logic   dataReq;
    logic   dataWe;
    addrT   dataAddr;
    wordT   dataWdata;
    logic   dataDone;
    wordT   dataRdata;
    logic   fwdValid;
    regIdxT fwdRd;
    wordT   fwdData;
    logic   wbWe;
    regIdxT wbRd;
    wordT   wbData;

    fetchUnit uFetch (.*);

    decodeStage uDecode (.*);

    executeStage uExecute (.*);

    memStage uMem (.*);

    memArbiter uArbiter (.*);

endmodule

// ==== sim/pipeCore_assert.sv ====
`timescale 1ns/1ns

module pipeCore_assert (
    input logic             clk,
    input logic             rstN,
    input logic             memReq,
    input logic             memWe,
    input coreDefs::addrT   memAddr,
    input coreDefs::wordT   memWdata,
    input logic             memReady,
    input logic             commitValid,
    input logic             commitRdWe,
    input coreDefs::regIdxT commitRd
);

    int assertFails = 0;

    // a waiting request keeps all its fields until the port answers
    property holdRequest;
        @(posedge clk) disable iff (!rstN)
            memReq && !memReady |=>
                memReq && $stable(memWe) && $stable(memAddr) && $stable(memWdata);
    endproperty

    property quietInReset;
        @(posedge clk) !rstN ##1 !rstN |-> !commitValid;
    endproperty

    // x0 is never reported as written
    property noZeroRd;
        @(posedge clk) disable iff (!rstN)
            commitValid && commitRdWe |-> commitRd != '0;
    endproperty

    assert property (holdRequest) else begin
        $error("memory request changed before memReady");
        assertFails++;
    end

    assert property (quietInReset) else begin
        $error("commitValid high during reset");
        assertFails++;
    end

    assert property (noZeroRd) else begin
        $error("commit reports a write to x0");
        assertFails++;
    end

endmodule

bind pipeCore pipeCore_assert uAssert (.*);

// ==== sim/pipeCoreTb.sv ====
`timescale 1ns/1ns

module pipeCoreTb;
    import coreDefs::*;

    localparam int memWords = 256;
    localparam int cyclesPerCommit = 40;

    logic   clk;
    logic   rstN;
    logic   memReq;
    logic   memWe;
    addrT   memAddr;
    wordT   memWdata;
    wordT   memRdata;
    logic   memReady;
    logic   commitValid;
    addrT   commitPc;
    logic   commitRdWe;
    regIdxT commitRd;
    wordT   commitData;

    integer seed = 32'hdadfb95a;
    int errorCount = 0;
    int commitCount = 0;
    int expectTotal = 0;
    logic allDone = 1'b0;

    wordT mem [memWords];
    wordT refMem [memWords];
    wordT refRegs [32];
    addrT refPc;
    addrT progPc;
    addrT haltPc;

    // expected commits in program order
    addrT   expPcQ [$];
    logic   expWeQ [$];
    regIdxT expRdQ [$];
    wordT   expDataQ [$];

    pipeCore u_dut (.*);

    function automatic instT addiInst(regIdxT rd, regIdxT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opImm};
    endfunction

    function automatic instT loadInst(regIdxT rd, regIdxT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, opLoad};
    endfunction

    function automatic instT storeInst(regIdxT rs2, regIdxT rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], opStore};
    endfunction

    // sub sets funct7 bit 30
    function automatic instT aluInst(logic [2:0] f3, logic sub, regIdxT rd,
                                     regIdxT rs1, regIdxT rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic instT branchInst(logic [2:0] f3, regIdxT rs1, regIdxT rs2,
                                        logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic instT jalInst(regIdxT rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    task automatic placeInst(instT inst);
        if (progPc[2]) begin
            mem[progPc[10:3]][63:32] = inst;
            refMem[progPc[10:3]][63:32] = inst;
        end else begin
            mem[progPc[10:3]][31:0] = inst;
            refMem[progPc[10:3]][31:0] = inst;
        end
        progPc = progPc + 64'd4;
    endtask

    // ISA model that retires one instruction per call
    function automatic void nextRefCommit(output addrT pc, output logic rdWe,
                                          output regIdxT rd, output wordT data);
        instT inst;
        wordT a;
        wordT b;
        wordT immI;
        wordT immS;
        wordT immB;
        wordT immJ;
        addrT ea;
        addrT nextPc;
        inst = refPc[2] ? refMem[refPc[10:3]][63:32] : refMem[refPc[10:3]][31:0];
        a = refRegs[inst[19:15]];
        b = refRegs[inst[24:20]];
        immI = 64'($signed(inst[31:20]));
        immS = 64'($signed({inst[31:25], inst[11:7]}));
        immB = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        immJ = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        pc = refPc;
        rd = inst[11:7];
        rdWe = 1'b0;
        data = '0;
        nextPc = refPc + 64'd4;
        case (inst[6:0])
            opReg: begin
                rdWe = 1'b1;
                case (inst[14:12])
                    3'b000: data = inst[30] ? a - b : a + b;
                    3'b100: data = a ^ b;
                    3'b110: data = a | b;
                    default: data = a & b;
                endcase
            end
            opImm: begin
                rdWe = 1'b1;
                data = a + immI;
            end
            opLoad: begin
                rdWe = 1'b1;
                ea = a + immI;
                data = refMem[ea[10:3]];
            end
            opStore: begin
                ea = a + immS;
                refMem[ea[10:3]] = b;
            end
            opBranch: begin
                if (inst[14:12] == f3Beq ? a == b : a != b) begin
                    nextPc = refPc + immB;
                end
            end
            default: begin
                rdWe = 1'b1;
                data = refPc + 64'd4;
                nextPc = refPc + immJ;
            end
        endcase
        if (rd == '0) begin
            rdWe = 1'b0;
        end
        if (rdWe) begin
            refRegs[rd] = data;
        end
        refPc = nextPc;
    endfunction

    task automatic addrCompare(string name, addrT got, addrT exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic idxCompare(string name, regIdxT got, regIdxT exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wordCompare(string name, wordT got, wordT exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic bitCompare(string name, logic got, logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory answers each request after 0 to 3 wait cycles
    initial begin : memModel
        int waitLeft;
        logic waiting;
        memReady = 1'b0;
        memRdata = '0;
        waiting = 1'b0;
        waitLeft = 0;
        forever begin
            @(negedge clk);
            if (memReady) begin
                memReady = 1'b0;
            end else if (rstN && memReq) begin
                if (!waiting) begin
                    waiting = 1'b1;
                    waitLeft = $unsigned($random(seed)) % 4;
                end
                if (waitLeft == 0) begin
                    waiting = 1'b0;
                    memReady = 1'b1;
                    memRdata = mem[memAddr[10:3]];
                    if (memWe) begin
                        mem[memAddr[10:3]] = memWdata;
                    end
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstN && commitValid && !allDone && expPcQ.size() > 0) begin
            addrCompare("commitPc", commitPc, expPcQ[0]);
            bitCompare("commitRdWe", commitRdWe, expWeQ[0]);
            if (expWeQ[0]) begin
                idxCompare("commitRd", commitRd, expRdQ[0]);
                wordCompare("commitData", commitData, expDataQ[0]);
            end
            void'(expPcQ.pop_front());
            void'(expWeQ.pop_front());
            void'(expRdQ.pop_front());
            void'(expDataQ.pop_front());
            commitCount++;
            if (expPcQ.size() == 0) begin
                allDone = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (expectTotal > 0);
        repeat (expectTotal * cyclesPerCommit + 5) @(posedge clk);
        $display("timeout, only %0d of %0d commits seen", commitCount, expectTotal);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : mainFlow
        addrT pc;
        logic we;
        regIdxT rd;
        wordT data;
        int totalErrors;
        rstN = 1'b0;
        for (int i = 0; i < memWords; i++) begin
            mem[i] = {32'(i) * 32'h9e3779b1, 32'hc0de0000 | 32'(i)};
            refMem[i] = mem[i];
        end
        progPc = resetPc;
        // dependent ALU chain
        placeInst(addiInst(1, 0, 5));
        placeInst(addiInst(2, 0, -3));
        placeInst(aluInst(3'b000, 1'b0, 3, 1, 2));
        placeInst(aluInst(3'b000, 1'b1, 4, 3, 1));
        placeInst(aluInst(3'b100, 1'b0, 5, 4, 3));
        placeInst(aluInst(3'b110, 1'b0, 6, 5, 1));
        placeInst(aluInst(3'b111, 1'b0, 7, 6, 4));
        // store then load back followed by a load-use
        placeInst(addiInst(8, 0, 12'h400));
        placeInst(storeInst(7, 8, 0));
        placeInst(loadInst(9, 8, 0));
        placeInst(aluInst(3'b000, 1'b0, 10, 9, 9));
        placeInst(loadInst(11, 8, 8));
        // taken beq, untaken bne, taken bne, jal
        placeInst(branchInst(f3Beq, 9, 7, 12));
        placeInst(addiInst(12, 0, 111));
        placeInst(addiInst(12, 0, 222));
        placeInst(branchInst(f3Bne, 1, 1, 8));
        placeInst(branchInst(f3Bne, 1, 2, 12));
        placeInst(addiInst(13, 0, 1));
        placeInst(addiInst(13, 0, 2));
        placeInst(jalInst(14, 12));
        placeInst(addiInst(15, 0, 7));
        placeInst(addiInst(15, 0, 8));
        placeInst(aluInst(3'b000, 1'b0, 15, 14, 11));
        placeInst(storeInst(15, 8, 16));
        placeInst(loadInst(16, 8, 16));
        placeInst(aluInst(3'b000, 1'b1, 17, 16, 10));
        // short counted loop
        placeInst(addiInst(18, 0, 4));
        placeInst(addiInst(17, 17, 3));
        placeInst(addiInst(18, 18, -1));
        placeInst(branchInst(f3Bne, 18, 0, -8));
        haltPc = progPc;
        placeInst(jalInst(0, 0));

        refPc = resetPc;
        foreach (refRegs[i]) begin
            refRegs[i] = '0;
        end
        do begin
            nextRefCommit(pc, we, rd, data);
            expPcQ.push_back(pc);
            expWeQ.push_back(we);
            expRdQ.push_back(rd);
            expDataQ.push_back(data);
        end while (pc != haltPc && expPcQ.size() < 1000);
        expectTotal = expPcQ.size();

        repeat (5) @(negedge clk);
        rstN = 1'b1;
        wait (allDone);
        totalErrors = errorCount + u_dut.uAssert.assertFails;
        $display("commits %0d of %0d, check errors %0d, assertion failures %0d",
                 commitCount, expectTotal, errorCount, u_dut.uAssert.assertFails);
        if (totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== pipeCore.f ====
source/coreDefs.sv
source/fetchUnit.sv
source/decodeStage.sv
source/executeStage.sv
source/memStage.sv
source/memArbiter.sv
source/pipeCore.sv
sim/pipeCore_assert.sv
sim/pipeCoreTb.sv
